// File: include/wino_config.svh
`ifndef WINO_CONFIG_SVH
`define WINO_CONFIG_SVH

// accumulator word carried through both transform passes.
`define WINO_ACC_W 30

// pixel keeps accumulator bits 23 down to 8.
`define WINO_PIX_W 16
`define WINO_PIX_LSB 8

// tile shape seen by the inverse transform.
`define WINO_TILE_ROWS 6
`define WINO_TILE_COLS 4

// downstream row credits after reset.
`define WINO_OUT_CREDITS 4
`define WINO_CRED_W 3 // must hold WINO_OUT_CREDITS.

`endif

// File: rtl/wino_at_row.sv
`timescale 1ns/1ps
`default_nettype none

module wino_at_row import wino_data_pkg::*; (
	input  logic clk,
	input  acc_t i_d_0,
	input  acc_t i_d_1,
	input  acc_t i_d_2,
	input  acc_t i_d_3,
	input  acc_t i_d_4,
	input  acc_t i_d_5,
	output acc_t o_r_0,
	output acc_t o_r_1,
	output acc_t o_r_2,
	output acc_t o_r_3
);

	acc_t s1_sum12;
	acc_t s1_dif12;
	acc_t s1_sum34;
	acc_t s1_dif34;
	acc_t s1_d0;
	acc_t s1_d5;
	acc_t s2_a [4];
	acc_t s2_b [4];

	// first stage shares the pair terms between all four rows.
	always_ff @(posedge clk) begin
		s1_sum12 <= i_d_1 + i_d_2;
		s1_dif12 <= i_d_1 - i_d_2;
		s1_sum34 <= i_d_3 + i_d_4;
		s1_dif34 <= i_d_3 - i_d_4;
		s1_d0    <= i_d_0;
		s1_d5    <= i_d_5;
	end

	always_ff @(posedge clk) begin
		s2_a[0] <= s1_d0 + s1_sum12;
		s2_b[0] <= s1_sum34;
		s2_a[1] <= s1_dif12;
		s2_b[1] <= s1_dif34 <<< 1; // 2*(d3 - d4).
		s2_a[2] <= s1_sum12;
		s2_b[2] <= s1_sum34 <<< 2; // 4*(d3 + d4).
		s2_a[3] <= s1_dif12 + s1_d5;
		s2_b[3] <= s1_dif34 <<< 3; // 8*(d3 - d4).
	end

	always_ff @(posedge clk) begin
		o_r_0 <= s2_a[0] + s2_b[0];
		o_r_1 <= s2_a[1] + s2_b[1];
		o_r_2 <= s2_a[2] + s2_b[2];
		o_r_3 <= s2_a[3] + s2_b[3];
	end

endmodule

`default_nettype wire

// File: rtl/wino_ctrl_pkg.sv
`default_nettype none

package wino_ctrl_pkg;

	// controller states.
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1, // rows arriving from upstream.
		FLUSH = 2'd2, // last rows still inside the row adder tree.
		DRAIN = 2'd3
	} wino_state_e;

	// which pass a pipeline slot belongs to.
	typedef enum logic {
		PASS_ROW = 1'b0,
		PASS_COL = 1'b1
	} wino_pass_e;

endpackage

`default_nettype wire

// File: rtl/wino_data_pkg.sv
`default_nettype none

package wino_data_pkg;

	`include "wino_config.svh"

	// signed sum of transform terms, wraps at WINO_ACC_W bits.
	typedef logic signed [`WINO_ACC_W-1:0] acc_t;

	// quantized output pixel.
	typedef logic [`WINO_PIX_W-1:0] pix_t;

endpackage

`default_nettype wire

// File: rtl/wino_inv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "wino_config.svh"

module wino_inv_ctrl import wino_ctrl_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_valid,
	input  logic i_out_credit,
	output logic o_buf_wr,
	output logic o_buf_shift,
	output logic o_col_valid,
	output logic o_in_credit
);

	localparam logic [2:0] LAST_ROW = 3'(`WINO_TILE_ROWS - 1);
	localparam logic [1:0] LAST_COL = 2'(`WINO_TILE_COLS - 1);

	wino_state_e state;
	logic [2:0] row_cnt;
	logic [2:0] wr_cnt;
	logic [1:0] col_cnt;
	logic [`WINO_CRED_W-1:0] credits;
	logic [1:0] vld_sr [3]; // bit index is a wino_pass_e.
	logic accept;
	logic issue;

	assign accept = i_valid && (state == IDLE || state == LOAD);
	assign issue = (state == DRAIN) && (credits != '0);

	assign o_buf_shift = issue;
	assign o_buf_wr    = vld_sr[2][PASS_ROW]; // row leaves wino_at_row_0.
	assign o_col_valid = vld_sr[2][PASS_COL]; // column leaves wino_at_row_1.

	// matches the three register stages of the adder tree.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			vld_sr[0] <= '0;
			vld_sr[1] <= '0;
			vld_sr[2] <= '0;
		end else begin
			vld_sr[0][PASS_ROW] <= accept;
			vld_sr[0][PASS_COL] <= issue;
			vld_sr[1] <= vld_sr[0];
			vld_sr[2] <= vld_sr[1];
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state       <= IDLE;
			row_cnt     <= '0;
			wr_cnt      <= '0;
			col_cnt     <= '0;
			o_in_credit <= 1'b0;
		end else begin
			o_in_credit <= 1'b0;
			if (o_buf_wr) begin
				wr_cnt <= (wr_cnt == LAST_ROW) ? 3'd0 : wr_cnt + 3'd1;
			end
			case (state)
				IDLE: begin
					if (accept) begin
						row_cnt <= 3'd1;
						state   <= LOAD;
					end
				end
				LOAD: begin
					if (accept) begin
						row_cnt <= row_cnt + 3'd1;
						if (row_cnt == LAST_ROW) state <= FLUSH;
					end
				end
				FLUSH: begin
					if (o_buf_wr && wr_cnt == LAST_ROW) state <= DRAIN;
				end
				DRAIN: begin
					if (issue) begin
						col_cnt <= col_cnt + 2'd1; // wraps to 0 after the last column.
						if (col_cnt == LAST_COL) begin
							state       <= IDLE;
							o_in_credit <= 1'b1; // buffer is free for the next tile.
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// downstream row credits.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			credits <= `WINO_CRED_W'(`WINO_OUT_CREDITS);
		end else begin
			case ({issue, i_out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/wino_inv_top.sv
`timescale 1ns/1ps
`default_nettype none

module wino_inv_top import wino_data_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_valid,
	input  acc_t i_row_0,
	input  acc_t i_row_1,
	input  acc_t i_row_2,
	input  acc_t i_row_3,
	input  acc_t i_row_4,
	input  acc_t i_row_5,
	input  logic i_out_credit,
	output logic o_in_credit,
	output logic o_valid,
	output pix_t o_pix_0,
	output pix_t o_pix_1,
	output pix_t o_pix_2,
	output pix_t o_pix_3
);

	logic buf_wr;
	logic buf_shift;
	logic col_valid;
	acc_t row_r_0, row_r_1, row_r_2, row_r_3; // row pass results.
	acc_t col_d_0, col_d_1, col_d_2, col_d_3, col_d_4, col_d_5;
	acc_t col_r_0, col_r_1, col_r_2, col_r_3;

	wino_inv_ctrl ctrl0 (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_valid      (i_valid),
		.i_out_credit (i_out_credit),
		.o_buf_wr     (buf_wr),
		.o_buf_shift  (buf_shift),
		.o_col_valid  (col_valid),
		.o_in_credit  (o_in_credit)
	);

	wino_at_row wino_at_row_0 (
		.clk   (clk),
		.i_d_0 (i_row_0), .i_d_1 (i_row_1), .i_d_2 (i_row_2),
		.i_d_3 (i_row_3), .i_d_4 (i_row_4), .i_d_5 (i_row_5),
		.o_r_0 (row_r_0), .o_r_1 (row_r_1), .o_r_2 (row_r_2), .o_r_3 (row_r_3)
	);

	wino_tile_buf buf0 (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wr    (buf_wr),
		.i_w_0   (row_r_0), .i_w_1 (row_r_1), .i_w_2 (row_r_2), .i_w_3 (row_r_3),
		.i_shift (buf_shift),
		.o_c_0   (col_d_0), .o_c_1 (col_d_1), .o_c_2 (col_d_2),
		.o_c_3   (col_d_3), .o_c_4 (col_d_4), .o_c_5 (col_d_5)
	);

	// column pass reads the buffer in the cycle of the issue.
	wino_at_row wino_at_row_1 (
		.clk   (clk),
		.i_d_0 (col_d_0), .i_d_1 (col_d_1), .i_d_2 (col_d_2),
		.i_d_3 (col_d_3), .i_d_4 (col_d_4), .i_d_5 (col_d_5),
		.o_r_0 (col_r_0), .o_r_1 (col_r_1), .o_r_2 (col_r_2), .o_r_3 (col_r_3)
	);

	wino_out_quant quant0 (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_valid (col_valid),
		.i_r_0   (col_r_0), .i_r_1 (col_r_1), .i_r_2 (col_r_2), .i_r_3 (col_r_3),
		.o_valid (o_valid),
		.o_pix_0 (o_pix_0), .o_pix_1 (o_pix_1), .o_pix_2 (o_pix_2), .o_pix_3 (o_pix_3)
	);

endmodule

`default_nettype wire

// File: rtl/wino_out_quant.sv
`timescale 1ns/1ps
`default_nettype none

`include "wino_config.svh"

module wino_out_quant import wino_data_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_valid,
	input  acc_t i_r_0,
	input  acc_t i_r_1,
	input  acc_t i_r_2,
	input  acc_t i_r_3,
	output logic o_valid,
	output pix_t o_pix_0,
	output pix_t o_pix_1,
	output pix_t o_pix_2,
	output pix_t o_pix_3
);

	// relu then keep the fixed-point window, no saturation.
	function automatic pix_t relu_slice(input acc_t a);
		return a[`WINO_ACC_W-1] ? '0 : a[`WINO_PIX_LSB +: `WINO_PIX_W];
	endfunction

	always_ff @(posedge clk) begin
		if (!i_rst_n) o_valid <= 1'b0;
		else o_valid <= i_valid;
	end

	always_ff @(posedge clk) begin
		o_pix_0 <= relu_slice(i_r_0);
		o_pix_1 <= relu_slice(i_r_1);
		o_pix_2 <= relu_slice(i_r_2);
		o_pix_3 <= relu_slice(i_r_3);
	end

endmodule

`default_nettype wire

// File: rtl/wino_tile_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "wino_config.svh"

module wino_tile_buf import wino_data_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_wr,
	input  acc_t i_w_0,
	input  acc_t i_w_1,
	input  acc_t i_w_2,
	input  acc_t i_w_3,
	input  logic i_shift,
	output acc_t o_c_0,
	output acc_t o_c_1,
	output acc_t o_c_2,
	output acc_t o_c_3,
	output acc_t o_c_4,
	output acc_t o_c_5
);

	localparam int ROWS = `WINO_TILE_ROWS;
	localparam int COLS = `WINO_TILE_COLS;

	// row 0 holds the oldest row, column 0 is the one presented.
	acc_t stack [ROWS][COLS];

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLS; c++) begin
					stack[r][c] <= '0;
				end
			end
		end else if (i_wr) begin
			for (int r = 0; r < ROWS - 1; r++) begin
				stack[r] <= stack[r+1];
			end
			stack[ROWS-1] <= '{i_w_0, i_w_1, i_w_2, i_w_3};
		end else if (i_shift) begin
			// rotate left so the next column comes to position 0.
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLS; c++) begin
					stack[r][c] <= stack[r][(c + 1) % COLS];
				end
			end
		end
	end

	assign o_c_0 = stack[0][0];
	assign o_c_1 = stack[1][0];
	assign o_c_2 = stack[2][0];
	assign o_c_3 = stack[3][0];
	assign o_c_4 = stack[4][0];
	assign o_c_5 = stack[5][0];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module wino_inv_tb -o wino_sim > build.log 2>&1 \
	&& ./obj_dir/wino_sim > sim.log 2>&1 \
	|| { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// File: sim/wino_inv_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "wino_config.svh"

module wino_inv_sva (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_valid,
	input wire logic i_out_credit,
	input wire logic o_in_credit,
	input wire logic o_valid
);

	int out_cnt;
	logic tile_seen; // a tile arrived since the last credit return.

	always @(posedge clk) begin
		if (!i_rst_n) begin
			out_cnt <= `WINO_OUT_CREDITS;
			tile_seen <= 1'b0;
		end else begin
			out_cnt <= out_cnt - int'(o_valid) + int'(i_out_credit);
			if (o_in_credit) tile_seen <= 1'b0;
			else if (i_valid) tile_seen <= 1'b1;
		end
	end

	a_valid_needs_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid |-> out_cnt > 0) else $error("o_valid without downstream credit");

	a_reset_quiet: assert property (@(posedge clk)
		!i_rst_n |=> (!o_valid && !o_in_credit)) else $error("outputs active around reset");

	a_one_return_per_tile: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_in_credit |-> tile_seen) else $error("tile credit returned twice");

endmodule

bind wino_inv_top wino_inv_sva sva0 (
	.clk (clk), .i_rst_n (i_rst_n), .i_valid (i_valid), .i_out_credit (i_out_credit),
	.o_in_credit (o_in_credit), .o_valid (o_valid)
);

`default_nettype wire

// File: sim/wino_inv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wino_config.svh"

module wino_inv_tb import wino_data_pkg::*; ();

	localparam int N_TESTS = 6;
	localparam int TIMEOUT_NS = N_TESTS * 200 * 100;

	logic clk;
	logic i_rst_n;
	logic i_valid;
	acc_t i_row_0, i_row_1, i_row_2, i_row_3, i_row_4, i_row_5;
	logic i_out_credit;
	logic o_in_credit;
	logic o_valid;
	pix_t o_pix_0, o_pix_1, o_pix_2, o_pix_3;

	// transform rows used by the model.
	int at_c [4][6] = '{'{1, 1, 1, 1, 1, 0}, '{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0}, '{0, 1, -1, 8, -8, 1}};
	int m [6][6];
	logic [63:0] exp_q [$];
	string cur_test;
	int seed = 41;
	int errors = 0;
	int err_start;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int out_cnt = 0;
	int in_cred_cnt = 0;
	logic tile_credit = 1'b1;
	logic auto_ret = 1'b1;
	logic man_cred = 1'b0;

	wino_inv_top dut0 (
		.clk (clk), .i_rst_n (i_rst_n), .i_valid (i_valid),
		.i_row_0 (i_row_0), .i_row_1 (i_row_1), .i_row_2 (i_row_2),
		.i_row_3 (i_row_3), .i_row_4 (i_row_4), .i_row_5 (i_row_5),
		.i_out_credit (i_out_credit), .o_in_credit (o_in_credit), .o_valid (o_valid),
		.o_pix_0 (o_pix_0), .o_pix_1 (o_pix_1), .o_pix_2 (o_pix_2), .o_pix_3 (o_pix_3)
	);

	always #50 clk = ~clk;

	// downstream returns a credit for each row, or on request.
	always @(posedge clk) begin
		i_out_credit <= (auto_ret && o_valid) || man_cred;
	end

	always @(negedge clk) begin
		if (o_valid) begin
			out_cnt++;
			assert (exp_q.size() != 0) else begin
				$display("%s: output row appeared with none expected", cur_test);
				errors++;
			end
			if (exp_q.size() != 0) begin
				assert ({o_pix_3, o_pix_2, o_pix_1, o_pix_0} == exp_q[0]) else begin
					$display("** Error: %s expected %h actual %h", cur_test, exp_q[0],
						{o_pix_3, o_pix_2, o_pix_1, o_pix_0});
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
		if (o_in_credit) begin
			in_cred_cnt++;
			tile_credit = 1'b1;
		end
	end

	function automatic logic [15:0] quant(input int v);
		return (v < 0) ? 16'd0 : 16'((v >>> `WINO_PIX_LSB) & 32'hffff);
	endfunction

	// output beat k carries column k of the transformed tile.
	task automatic model_tile();
		int t [6][4];
		int y [4][4];
		for (int r = 0; r < 6; r++)
			for (int k = 0; k < 4; k++) begin
				t[r][k] = 0;
				for (int j = 0; j < 6; j++) t[r][k] += at_c[k][j] * m[r][j];
			end
		for (int i = 0; i < 4; i++)
			for (int k = 0; k < 4; k++) begin
				y[i][k] = 0;
				for (int r = 0; r < 6; r++) y[i][k] += at_c[i][r] * t[r][k];
			end
		for (int k = 0; k < 4; k++)
			exp_q.push_back({quant(y[3][k]), quant(y[2][k]), quant(y[1][k]), quant(y[0][k])});
	endtask

	task automatic send_tile();
		wait (tile_credit);
		tile_credit = 1'b0;
		model_tile();
		for (int r = 0; r < 6; r++) begin
			@(posedge clk);
			i_valid <= 1'b1;
			i_row_0 <= acc_t'(m[r][0]);
			i_row_1 <= acc_t'(m[r][1]);
			i_row_2 <= acc_t'(m[r][2]);
			i_row_3 <= acc_t'(m[r][3]);
			i_row_4 <= acc_t'(m[r][4]);
			i_row_5 <= acc_t'(m[r][5]);
		end
		@(posedge clk);
		i_valid <= 1'b0;
	endtask

	task automatic grant_credit();
		@(posedge clk);
		man_cred <= 1'b1;
		@(posedge clk);
		man_cred <= 1'b0;
	endtask

	task automatic wait_drain();
		int n = 0;
		while (exp_q.size() != 0 && n < 100) begin
			@(posedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%s: %0d output rows never arrived", cur_test, exp_q.size());
			errors++;
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_start = errors;
	endtask

	task automatic end_test();
		if (errors == err_start) begin
			pass_cnt++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", cur_test, errors - err_start);
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: the run did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int base;
		int lat;
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_out_credit = 1'b0;
		{i_row_0, i_row_1, i_row_2, i_row_3, i_row_4, i_row_5} = '0;

		start_test("reset");
		repeat (3) @(posedge clk);
		i_rst_n <= 1'b1;
		repeat (6) begin
			@(negedge clk);
			assert (!o_valid && !o_in_credit) else begin
				$display("%s: outputs active with no input", cur_test);
				errors++;
			end
		end
		end_test();

		start_test("known_tile");
		for (int r = 0; r < 6; r++)
			for (int c = 0; c < 6; c++) m[r][c] = 256 * (r + c + 1);
		send_tile();
		wait_drain();
		end_test();

		start_test("negative_relu");
		for (int r = 0; r < 6; r++)
			for (int c = 0; c < 6; c++) m[r][c] = (((r + c) % 2) ? -700 : 300) * (c + 1);
		send_tile();
		wait_drain();
		end_test();

		start_test("random_back_to_back");
		base = in_cred_cnt;
		for (int t = 0; t < 4; t++) begin
			for (int r = 0; r < 6; r++)
				for (int c = 0; c < 6; c++) m[r][c] = $random(seed) % 65536;
			send_tile();
		end
		wait_drain();
		assert (in_cred_cnt - base == 4) else begin
			$display("%s: %0d tile credits returned for 4 tiles", cur_test, in_cred_cnt - base);
			errors++;
		end
		end_test();

		start_test("credit_starvation");
		auto_ret = 1'b0;
		for (int t = 0; t < 2; t++) begin
			for (int r = 0; r < 6; r++)
				for (int c = 0; c < 6; c++) m[r][c] = $random(seed) % 65536;
			send_tile();
		end
		repeat (40) @(negedge clk);
		assert (exp_q.size() == 4) else begin
			$display("%s: rows issued without downstream credit", cur_test);
			errors++;
		end
		repeat (4) begin
			grant_credit();
			repeat (2) @(posedge clk);
		end
		wait_drain();
		end_test();

		start_test("latency");
		for (int r = 0; r < 6; r++)
			for (int c = 0; c < 6; c++) m[r][c] = $random(seed) % 65536;
		send_tile();
		repeat (20) @(negedge clk);
		for (int k = 0; k < 4; k++) begin
			base = out_cnt;
			lat = 0;
			grant_credit();
			while (out_cnt == base && lat < 12) begin
				@(posedge clk);
				lat++;
			end
			// one edge to the issue, four to o_valid, one more to see it.
			assert (lat <= 6) else begin
				$display("%s: row %0d came %0d cycles after its credit", cur_test, k, lat);
				errors++;
			end
		end
		wait_drain();
		end_test();

		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
rtl/wino_ctrl_pkg.sv
rtl/wino_data_pkg.sv
rtl/wino_at_row.sv
rtl/wino_tile_buf.sv
rtl/wino_inv_ctrl.sv
rtl/wino_out_quant.sv
rtl/wino_inv_top.sv
sim/wino_inv_sva.sv
sim/wino_inv_tb.sv
